// File: src/saxi_wr_defs.svh
// shared sizing macros for the multi-channel AXI write gatherer
// channel count, burst length, output FIFO depth
`ifndef SAXI_WR_DEFS_SVH
`define SAXI_WR_DEFS_SVH

// number of source channels
`define SAXI_NUM_CHN   4

// burst length in 32-bit words, log2 first
`define SAXI_BURST_LOG 4
`define SAXI_BURST_LEN 16

// output FIFO holds 2 ** SAXI_FIFO_LOG words (two bursts)
`define SAXI_FIFO_LOG  5

`endif

// File: src/saxi_wr_pkg.sv
// types shared by the AXI write gatherer
// data word, word address, channel number and mask, burst beat,
// FIFO fill level, arbiter FSM states
`include "saxi_wr_defs.svh"

package saxi_wr_pkg;

    typedef logic [31:0]                       word_t;     // one source word
    typedef logic [29:0]                       waddr_t;    // word address, byte addr >> 2
    typedef logic [$clog2(`SAXI_NUM_CHN)-1:0]  chn_t;      // channel number
    typedef logic [`SAXI_NUM_CHN-1:0]          chn_mask_t; // one bit per channel
    typedef logic [`SAXI_BURST_LOG-1:0]        beat_t;     // word index in burst
    typedef logic [`SAXI_FIFO_LOG:0]           fifo_cnt_t; // 0 .. depth inclusive

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE,  // nothing outstanding
        ARB_GRANT, // grant pulse cycle
        ARB_WAIT   // previous burst still gathering or AW pending
    } arb_state_t;

endpackage

// File: src/wfifo_if.sv
// push side of the tagged write data FIFO
// gatherer drives word, tag and last, FIFO returns free space
`include "saxi_wr_defs.svh"

interface wfifo_if import saxi_wr_pkg::*; ();

    logic      push;  // one word this cycle
    word_t     word;  // source data
    chn_t      chn;   // channel tag, becomes wid
    logic      last;  // final beat of burst, becomes wlast
    fifo_cnt_t free;  // empty entries

    // burst gatherer side
    modport gather_mp (
        output push,
        output word,
        output chn,
        output last,
        input  free
    );

    // FIFO side
    modport fifo_mp (
        input  push,
        input  word,
        input  chn,
        input  last,
        output free
    );

endinterface

// File: src/rr_arbiter.sv
// round-robin burst arbiter
// waits for gatherer idle, no AW in flight and a burst worth of FIFO room,
// then grants the next requesting channel after the last winner
`include "saxi_wr_defs.svh"

module rr_arbiter import saxi_wr_pkg::*; (
    input  logic      aclk,
    input  logic      mclk,          // async reset, active high
    input  chn_mask_t req_i,         // has_burst & enable
    input  logic      gather_busy_i,
    input  logic      aw_pending_i,
    input  fifo_cnt_t fifo_free_i,
    output logic      grant_o,       // single cycle
    output chn_t      grant_chn_o,
    output chn_mask_t grant_mask_o   // one-hot read_burst pulse
);

    arb_state_t state_r;
    chn_t       last_chn_r; // previous winner
    chn_t       win_chn;
    logic       win_found;
    logic       path_clear; // downstream can take a burst

    assign path_clear = !gather_busy_i && !aw_pending_i &&
                        (fifo_free_i >= fifo_cnt_t'(`SAXI_BURST_LEN));

    // search starts one past the last winner and wraps via chn_t width
    always_comb begin : search
        chn_t idx;
        win_found = 1'b0;
        win_chn   = last_chn_r;
        for (int i = 1; i <= `SAXI_NUM_CHN; i++) begin
            idx = last_chn_r + chn_t'(i);
            if (!win_found && req_i[idx]) begin
                win_found = 1'b1;
                win_chn   = idx;
            end
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            state_r      <= ARB_IDLE;
            grant_o      <= 1'b0;
            grant_chn_o  <= '0;
            grant_mask_o <= '0;
            last_chn_r   <= chn_t'(`SAXI_NUM_CHN - 1); // first search hits chn 0
        end else begin
            grant_o      <= 1'b0; // pulse only
            grant_mask_o <= '0;
            case (state_r)
                ARB_IDLE, ARB_WAIT: begin
                    if (path_clear && win_found) begin
                        grant_o      <= 1'b1;
                        grant_chn_o  <= win_chn;
                        grant_mask_o <= chn_mask_t'(1) << win_chn;
                        last_chn_r   <= win_chn;
                        state_r      <= ARB_GRANT;
                    end else if (path_clear) begin
                        state_r <= ARB_IDLE; // drained and nobody asking
                    end
                end
                ARB_GRANT: state_r <= ARB_WAIT; // busy/awvalid take over next
                default:   state_r <= ARB_IDLE;
            endcase
        end
    end

    // at most one read pulse per cycle
    a_grant_mask: assert property (@(posedge aclk) disable iff (mclk)
        $onehot0(grant_mask_o));

endmodule

// File: src/chn_pointers.sv
// per-channel ring buffer registers and the AXI AW address stage
// start and length written from the config port, word pointer per channel
// advanced one burst per grant, wraps to zero at the region length
`include "saxi_wr_defs.svh"

module chn_pointers import saxi_wr_pkg::*; (
    input  logic   aclk,
    input  logic   mclk,          // async reset, active high
    // configuration
    input  logic   cfg_we_i,
    input  chn_t   cfg_chn_i,
    input  logic   cfg_len_sel_i, // 1: length, 0: start
    input  waddr_t cfg_data_i,    // in words
    // from arbiter
    input  logic   grant_i,
    input  chn_t   grant_chn_i,
    // AXI AW
    input  logic   awready_i,
    output waddr_t awaddr_o,      // word address
    output chn_t   awid_o,
    output logic   awvalid_o      // also aw_pending to arbiter
);

    waddr_t start_r [`SAXI_NUM_CHN]; // region start
    waddr_t len_r   [`SAXI_NUM_CHN]; // region length, multiple of burst
    waddr_t ptr_r   [`SAXI_NUM_CHN]; // offset of next burst
    waddr_t ptr_cur;
    waddr_t ptr_next;
    logic   ptr_wrap;

    assign ptr_cur  = ptr_r[grant_chn_i];
    assign ptr_next = ptr_cur + waddr_t'(`SAXI_BURST_LEN);
    assign ptr_wrap = (ptr_next >= len_r[grant_chn_i]); // end of ring

    // region registers and AW payload
    always_ff @(posedge aclk) begin
        if (cfg_we_i && cfg_len_sel_i) begin
            len_r[cfg_chn_i] <= cfg_data_i;
        end
        if (cfg_we_i && !cfg_len_sel_i) begin
            start_r[cfg_chn_i] <= cfg_data_i;
        end
        if (grant_i) begin
            awaddr_o <= start_r[grant_chn_i] + ptr_cur; // held until awready
            awid_o   <= grant_chn_i;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            for (int i = 0; i < `SAXI_NUM_CHN; i++) begin
                ptr_r[i] <= '0;
            end
            awvalid_o <= 1'b0;
        end else begin
            if (grant_i) begin
                ptr_r[grant_chn_i] <= ptr_wrap ? '0 : ptr_next;
            end
            if (cfg_we_i) begin
                ptr_r[cfg_chn_i] <= '0; // any cfg write restarts the ring and wins over grant
            end
            if (grant_i) begin
                awvalid_o <= 1'b1; // one cycle after grant
            end else if (awready_i) begin
                awvalid_o <= 1'b0;
            end
        end
    end

    // AW held under back-pressure
    a_aw_stable: assert property (@(posedge aclk) disable iff (mclk)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awid_o));

    // arbiter never grants over an unaccepted address
    a_aw_no_overrun: assert property (@(posedge aclk) disable iff (mclk)
        grant_i |-> !awvalid_o);

endmodule

// File: src/burst_gather.sv
// burst gatherer between the sources and the write data FIFO
// latches the granted channel, forwards its next BURST_LEN valid words
// tagged with the channel, marks the final beat as last
`include "saxi_wr_defs.svh"

module burst_gather import saxi_wr_pkg::*; (
    input  logic      aclk,
    input  logic      mclk,                          // async reset, active high
    input  logic      grant_i,                       // same cycle as read_burst
    input  chn_t      grant_chn_i,
    input  word_t     chn_data_i [`SAXI_NUM_CHN],
    input  chn_mask_t chn_valid_i,
    output logic      busy_o,
    wfifo_if.gather_mp fifo
);

    logic  busy_r;    // burst in progress
    chn_t  chn_r;     // channel being gathered
    beat_t beat_r;    // words already pushed
    logic  last_beat;

    assign last_beat = (beat_r == beat_t'(`SAXI_BURST_LEN - 1));

    // source words go straight into the FIFO, no staging
    assign fifo.push = busy_r && chn_valid_i[chn_r];
    assign fifo.word = chn_data_i[chn_r];
    assign fifo.chn  = chn_r;
    assign fifo.last = last_beat;

    assign busy_o = busy_r; // grant cycle held off by the arbiter FSM

    always_ff @(posedge aclk) begin
        if (grant_i) begin
            chn_r <= grant_chn_i;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            busy_r <= 1'b0;
            beat_r <= '0;
        end else if (grant_i) begin
            busy_r <= 1'b1;
            beat_r <= '0;
        end else if (fifo.push) begin
            beat_r <= beat_r + beat_t'(1); // wraps to 0 after last
            if (last_beat) begin
                busy_r <= 1'b0; // done on the last word
            end
        end
    end

    // arbiter reserved room for the whole burst
    a_push_room: assert property (@(posedge aclk) disable iff (mclk)
        fifo.push |-> (fifo.free != '0));

    // one burst at a time
    a_no_regrant: assert property (@(posedge aclk) disable iff (mclk)
        grant_i |-> !busy_r);

endmodule

// File: src/wdata_fifo.sv
// tagged write data FIFO feeding AXI W
// register array with read/write pointers and a fill count,
// pops on the W handshake, reports free space to the gatherer
`include "saxi_wr_defs.svh"

module wdata_fifo import saxi_wr_pkg::*; (
    input  logic    aclk,
    input  logic    mclk,     // async reset, active high
    wfifo_if.fifo_mp fifo,
    // AXI W
    input  logic    wready_i,
    output word_t   wdata_o,
    output chn_t    wid_o,
    output logic    wlast_o,
    output logic    wvalid_o
);

    localparam int DEPTH = 1 << `SAXI_FIFO_LOG;

    typedef logic [`SAXI_FIFO_LOG-1:0] fptr_t; // entry index

    word_t                    data_mem [DEPTH];
    chn_t                     chn_mem  [DEPTH]; // wid tag
    logic                     last_mem [DEPTH]; // wlast tag
    fptr_t                    wr_ptr_r;
    fptr_t                    rd_ptr_r;
    fifo_cnt_t                cnt_r;            // fill level
    logic                     pop;

    assign wvalid_o  = (cnt_r != '0);
    assign pop       = wvalid_o && wready_i; // W handshake
    assign wdata_o   = data_mem[rd_ptr_r];   // head, visible cycle after push
    assign wid_o     = chn_mem[rd_ptr_r];
    assign wlast_o   = last_mem[rd_ptr_r];
    assign fifo.free = fifo_cnt_t'(DEPTH) - cnt_r;

    always_ff @(posedge aclk) begin
        if (fifo.push) begin
            data_mem[wr_ptr_r] <= fifo.word;
            chn_mem[wr_ptr_r]  <= fifo.chn;
            last_mem[wr_ptr_r] <= fifo.last;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            cnt_r    <= '0;
        end else begin
            if (fifo.push) wr_ptr_r <= wr_ptr_r + fptr_t'(1);
            if (pop)       rd_ptr_r <= rd_ptr_r + fptr_t'(1);
            if (fifo.push && !pop) begin
                cnt_r <= cnt_r + fifo_cnt_t'(1);
            end else if (pop && !fifo.push) begin
                cnt_r <= cnt_r - fifo_cnt_t'(1);
            end
        end
    end

    a_no_overfill: assert property (@(posedge aclk) disable iff (mclk)
        cnt_r <= fifo_cnt_t'(DEPTH));

    // W payload held under back-pressure
    a_w_stable: assert property (@(posedge aclk) disable iff (mclk)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) &&
                                  $stable(wid_o) && $stable(wlast_o));

endmodule

// File: src/mult_saxi_wr.sv
// top of the four-channel AXI3 write gatherer
// arbiter, ring pointers / AW stage, burst gatherer, W data FIFO,
// source and config ports in plain form, AXI ids widened to 6 bits
`include "saxi_wr_defs.svh"

module mult_saxi_wr import saxi_wr_pkg::*; (
    input  logic        aclk,
    input  logic        mclk,          // async reset, active high
    // sources
    input  chn_mask_t   has_burst_i,   // at least one burst ready
    output chn_mask_t   read_burst_o,  // one pulse per burst
    input  word_t       chn_data0_i,
    input  word_t       chn_data1_i,
    input  word_t       chn_data2_i,
    input  word_t       chn_data3_i,
    input  chn_mask_t   chn_valid_i,   // per-word strobe
    // configuration
    input  logic        cfg_we_i,
    input  chn_t        cfg_chn_i,
    input  logic        cfg_len_sel_i, // length / start select
    input  waddr_t      cfg_data_i,
    input  chn_mask_t   en_chn_i,
    // AXI AW
    output logic [31:0] awaddr_o,      // byte address
    output logic [5:0]  awid_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    // AXI W
    output word_t       wdata_o,
    output logic [5:0]  wid_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i
);

    word_t     chn_data [`SAXI_NUM_CHN];
    chn_mask_t req;
    logic      grant;
    chn_t      grant_chn;
    logic      gather_busy;
    waddr_t    aw_word_addr;
    chn_t      aw_chn;
    logic      aw_valid;  // doubles as aw_pending
    chn_t      w_chn;

    wfifo_if u_wfifo ();

    assign chn_data[0] = chn_data0_i;
    assign chn_data[1] = chn_data1_i;
    assign chn_data[2] = chn_data2_i;
    assign chn_data[3] = chn_data3_i;

    assign req       = has_burst_i & en_chn_i; // disabled channels never requested
    assign awaddr_o  = {aw_word_addr, 2'b00};
    assign awid_o    = {{(6 - $bits(chn_t)){1'b0}}, aw_chn};
    assign wid_o     = {{(6 - $bits(chn_t)){1'b0}}, w_chn};
    assign awvalid_o = aw_valid;

    rr_arbiter u_arb (
        .aclk          (aclk),
        .mclk          (mclk),
        .req_i         (req),
        .gather_busy_i (gather_busy),
        .aw_pending_i  (aw_valid),
        .fifo_free_i   (u_wfifo.free),
        .grant_o       (grant),
        .grant_chn_o   (grant_chn),
        .grant_mask_o  (read_burst_o)
    );

    chn_pointers u_ptrs (
        .aclk          (aclk),
        .mclk          (mclk),
        .cfg_we_i      (cfg_we_i),
        .cfg_chn_i     (cfg_chn_i),
        .cfg_len_sel_i (cfg_len_sel_i),
        .cfg_data_i    (cfg_data_i),
        .grant_i       (grant),
        .grant_chn_i   (grant_chn),
        .awready_i     (awready_i),
        .awaddr_o      (aw_word_addr),
        .awid_o        (aw_chn),
        .awvalid_o     (aw_valid)
    );

    burst_gather u_gather (
        .aclk          (aclk),
        .mclk          (mclk),
        .grant_i       (grant),
        .grant_chn_i   (grant_chn),
        .chn_data_i    (chn_data),
        .chn_valid_i   (chn_valid_i),
        .busy_o        (gather_busy),
        .fifo          (u_wfifo.gather_mp)
    );

    wdata_fifo u_wfifo_mem (
        .aclk          (aclk),
        .mclk          (mclk),
        .fifo          (u_wfifo.fifo_mp),
        .wready_i      (wready_i),
        .wdata_o       (wdata_o),
        .wid_o         (w_chn),
        .wlast_o       (wlast_o),
        .wvalid_o      (wvalid_o)
    );

endmodule

// File: test/tb_mult_saxi_wr.sv
// testbench for the four-channel AXI write gatherer
// clock and reset, source models with random gaps, AXI ready throttling,
// scoreboard of grants, AW addresses and ids, W words, watchdog and report
`include "saxi_wr_defs.svh"

module tb_mult_saxi_wr import saxi_wr_pkg::*; ();

    localparam int NBURSTS    = 24 + 8 + 40;              // bursts over all tests
    localparam int RUN_CYCLES = 12 + NBURSTS * 40 + 400;  // 40 cycles per burst worst case

    logic        aclk;
    logic        mclk;
    chn_mask_t   has_burst_i;
    chn_mask_t   read_burst_o;
    word_t       src_data [`SAXI_NUM_CHN] = '{default: '0};
    chn_mask_t   chn_valid_i = '0;
    logic        cfg_we_i;
    chn_t        cfg_chn_i;
    logic        cfg_len_sel_i;
    waddr_t      cfg_data_i;
    chn_mask_t   en_chn_i;
    logic [31:0] awaddr_o;
    logic [5:0]  awid_o;
    logic        awvalid_o;
    logic        awready_i = 1'b1;
    word_t       wdata_o;
    logic [5:0]  wid_o;
    logic        wlast_o;
    logic        wvalid_o;
    logic        wready_i = 1'b1;

    // stimulus control, driven from the main sequence only
    logic        started   = 1'b0;  // first config not yet done
    logic        rr_check  = 1'b0;  // all channels requesting
    logic        throttle  = 1'b0;  // random AXI ready
    logic        end_check = 1'b0;
    chn_mask_t   off_mask  = '0;    // channels disabled in this test

    // scoreboard state, owned by the scoreboard block
    int          grant_q [$];       // channel order of read pulses
    int          aw_cnt = 0;
    int          w_words = 0;
    int          w_grp = 0;
    int          w_beat = 0;
    int          n_fail = 0;
    int          rr_prev = 0;
    logic        rr_prev_ok = 1'b0;
    waddr_t      exp_start [`SAXI_NUM_CHN] = '{default: '0};
    waddr_t      exp_len   [`SAXI_NUM_CHN] = '{default: '0};
    waddr_t      exp_ptr   [`SAXI_NUM_CHN] = '{default: '0};
    logic [29:0] exp_cnt   [`SAXI_NUM_CHN] = '{default: '0}; // next running count
    chn_mask_t   en_q = '0;
    logic        aw_hold = 1'b0;
    logic        w_hold = 1'b0;
    logic [31:0] aw_addr_q = '0;
    logic [5:0]  aw_id_q = '0;
    logic [5:0]  w_id_q = '0;
    word_t       w_data_q = '0;
    logic        w_last_q = 1'b0;

    // source model state
    logic [29:0] src_cnt    [`SAXI_NUM_CHN] = '{default: '0};
    int          words_left [`SAXI_NUM_CHN] = '{default: 0};

    mult_saxi_wr u_dut (
        .aclk (aclk), .mclk (mclk),
        .has_burst_i (has_burst_i), .read_burst_o (read_burst_o),
        .chn_data0_i (src_data[0]), .chn_data1_i (src_data[1]),
        .chn_data2_i (src_data[2]), .chn_data3_i (src_data[3]),
        .chn_valid_i (chn_valid_i),
        .cfg_we_i (cfg_we_i), .cfg_chn_i (cfg_chn_i),
        .cfg_len_sel_i (cfg_len_sel_i), .cfg_data_i (cfg_data_i),
        .en_chn_i (en_chn_i),
        .awaddr_o (awaddr_o), .awid_o (awid_o), .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o (wdata_o), .wid_o (wid_o), .wlast_o (wlast_o),
        .wvalid_o (wvalid_o), .wready_i (wready_i)
    );

    always #20 aclk = ~aclk;

    task automatic note_mismatch(input string msg);
        n_fail = n_fail + 1;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // each source sends one burst of 16 words with random gaps per read pulse
    always @(posedge aclk) begin : source_model
        for (int c = 0; c < `SAXI_NUM_CHN; c++) begin
            if (read_burst_o[c]) words_left[c] = words_left[c] + `SAXI_BURST_LEN;
            if (words_left[c] > 0 && ($urandom % 4) != 0) begin
                chn_valid_i[c] <= 1'b1;
                src_data[c]    <= {chn_t'(c), src_cnt[c]}; // chn on top, count below
                src_cnt[c]     = src_cnt[c] + 30'd1;
                words_left[c]  = words_left[c] - 1;
            end else begin
                chn_valid_i[c] <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin : ready_throttle
        awready_i <= !throttle || (($urandom % 3) != 0);
        wready_i  <= !throttle || (($urandom % 3) != 0);
    end

    always @(posedge aclk) begin : scoreboard
        int c;
        if (!mclk) begin
            if (!started) begin
                assert (read_burst_o == '0 && !awvalid_o && !wvalid_o)
                    else note_mismatch("outputs active before first request");
            end
            if (aw_hold) begin
                assert (awvalid_o && awaddr_o == aw_addr_q && awid_o == aw_id_q)
                    else note_mismatch("AW changed while stalled");
            end
            if (w_hold) begin
                assert (wvalid_o && wdata_o == w_data_q && wid_o == w_id_q &&
                        wlast_o == w_last_q)
                    else note_mismatch("W changed while stalled");
            end
            aw_hold   <= awvalid_o && !awready_i;
            aw_addr_q <= awaddr_o;
            aw_id_q   <= awid_o;
            w_hold    <= wvalid_o && !wready_i;
            w_data_q  <= wdata_o;
            w_id_q    <= wid_o;
            w_last_q  <= wlast_o;
            // en_q is the enable the arbiter saw for this pulse
            assert ((read_burst_o & ~en_q) == '0)
                else note_mismatch($sformatf("read pulse %b to disabled chn", read_burst_o));
            for (int i = 0; i < `SAXI_NUM_CHN; i++) begin
                if (read_burst_o[i]) grant_q.push_back(i);
            end
            en_q <= en_chn_i;
            if (awvalid_o && awready_i) begin
                c = int'(awid_o[1:0]);
                assert (awid_o[5:2] == 4'd0 && aw_cnt < grant_q.size() && c == grant_q[aw_cnt])
                    else note_mismatch($sformatf("awid %0d out of grant order", awid_o));
                assert (awaddr_o == {exp_start[c] + exp_ptr[c], 2'b00})
                    else note_mismatch($sformatf("chn %0d awaddr %h", c, awaddr_o));
                assert (!off_mask[c])
                    else note_mismatch($sformatf("awid %0d of a disabled chn", c));
                if (rr_check && rr_prev_ok) begin
                    assert (c == (rr_prev + 1) % `SAXI_NUM_CHN)
                        else note_mismatch($sformatf("awid %0d after %0d", c, rr_prev));
                end
                rr_prev    = c;
                rr_prev_ok = 1'b1;
                exp_ptr[c] = (exp_ptr[c] + waddr_t'(`SAXI_BURST_LEN)) % exp_len[c]; // ring wrap
                aw_cnt = aw_cnt + 1;
            end
            if (!rr_check) rr_prev_ok = 1'b0;
            if (cfg_we_i) begin
                c = int'(cfg_chn_i);
                if (cfg_len_sel_i) exp_len[c] = cfg_data_i;
                else exp_start[c] = cfg_data_i;
                exp_ptr[c] = '0; // any write restarts the ring
            end
            if (wvalid_o && wready_i) begin
                c = int'(wid_o[1:0]);
                assert (wid_o[5:2] == 4'd0 && w_grp < grant_q.size() && c == grant_q[w_grp])
                    else note_mismatch($sformatf("wid %0d out of AW order", wid_o));
                assert (wdata_o == {chn_t'(c), exp_cnt[c]})
                    else note_mismatch($sformatf("chn %0d wdata %h", c, wdata_o));
                assert (wlast_o == (w_beat == `SAXI_BURST_LEN - 1))
                    else note_mismatch($sformatf("wlast %b on beat %0d", wlast_o, w_beat));
                exp_cnt[c] = exp_cnt[c] + 30'd1;
                w_words    = w_words + 1;
                w_beat     = (w_beat + 1) % `SAXI_BURST_LEN;
                if (w_beat == 0) w_grp = w_grp + 1; // next burst group
            end
            if (end_check) begin
                assert (w_words == `SAXI_BURST_LEN * aw_cnt && aw_cnt == grant_q.size())
                    else note_mismatch($sformatf("%0d words for %0d AW", w_words, aw_cnt));
            end
        end
    end

    // called right after a rising edge
    task automatic write_cfg(input int chn, input logic len_sel, input waddr_t data);
        cfg_we_i      <= 1'b1;
        cfg_chn_i     <= chn_t'(chn);
        cfg_len_sel_i <= len_sel;
        cfg_data_i    <= data;
        @(posedge aclk);
        cfg_we_i      <= 1'b0;
    endtask

    task automatic run_bursts(input int n);
        int target;
        target = grant_q.size() + n;
        while (grant_q.size() < target) @(negedge aclk);
        @(posedge aclk);
    endtask

    // no source has words left to send
    function automatic logic sources_idle();
        for (int i = 0; i < `SAXI_NUM_CHN; i++) begin
            if (words_left[i] != 0) begin
                return 1'b0;
            end
        end
        return chn_valid_i == '0;
    endfunction

    // stop requests and wait until every granted burst is out on AW and W
    task automatic drain_bursts();
        has_burst_i <= '0;
        rr_check    <= 1'b0;
        repeat (3) @(posedge aclk);
        while (aw_cnt != grant_q.size() || !sources_idle() || wvalid_o)
            @(negedge aclk);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %-10s done, %0d failed checks", name, n_fail - fails_before);
    endtask

    initial begin : watchdog
        #(RUN_CYCLES * 40);
        $display("watchdog expired, bursts did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main_seq
        int seed_val;
        int f0;
        seed_val      = $urandom(32'hbd55ae93);
        aclk          = 1'b0;
        mclk          = 1'b1;
        has_burst_i   = '0;
        cfg_we_i      = 1'b0;
        cfg_chn_i     = '0;
        cfg_len_sel_i = 1'b0;
        cfg_data_i    = '0;
        en_chn_i      = '0;
        repeat (4) @(posedge aclk);
        mclk <= 1'b0;
        repeat (8) @(posedge aclk); // idle window after reset
        started <= 1'b1;
        @(negedge aclk);
        report_test("reset_idle", 0);
        // four rings, ch0 wraps after 5 bursts, ch3 every burst
        f0 = n_fail;
        @(posedge aclk);
        write_cfg(0, 1'b0, 30'h0000100);
        write_cfg(0, 1'b1, 30'd80);
        write_cfg(1, 1'b0, 30'h0001000);
        write_cfg(1, 1'b1, 30'd32);
        write_cfg(2, 1'b0, 30'h0002000);
        write_cfg(2, 1'b1, 30'd48);
        write_cfg(3, 1'b0, 30'h3fff000);
        write_cfg(3, 1'b1, 30'd16);
        en_chn_i    <= 4'hf;
        has_burst_i <= 4'hf;
        rr_check    <= 1'b1;
        run_bursts(24);
        drain_bursts();
        report_test("ring_wrap", f0);
        // new start and length, channels 1 and 3 off but still requesting
        f0 = n_fail;
        @(posedge aclk);
        write_cfg(0, 1'b0, 30'h0002400);
        write_cfg(2, 1'b1, 30'd64);
        en_chn_i    <= 4'b0101;
        off_mask    <= 4'b1010;
        has_burst_i <= 4'hf;
        run_bursts(8);
        drain_bursts();
        report_test("reconfig", f0);
        // all channels with random AW and W stalls
        f0 = n_fail;
        @(posedge aclk);
        off_mask    <= '0;
        en_chn_i    <= 4'hf;
        has_burst_i <= 4'hf;
        rr_check    <= 1'b1;
        throttle    <= 1'b1;
        run_bursts(40);
        drain_bursts();
        @(posedge aclk);
        throttle  <= 1'b0;
        end_check <= 1'b1;
        @(posedge aclk);
        end_check <= 1'b0;
        @(negedge aclk);
        report_test("stalls", f0);
        $display("tests 4, AW bursts %0d, W words %0d, failed checks %0d",
                 aw_cnt, w_words, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/saxi_wr_pkg.sv
src/wfifo_if.sv
src/rr_arbiter.sv
src/chn_pointers.sv
src/burst_gather.sv
src/wdata_fifo.sv
src/mult_saxi_wr.sv
test/tb_mult_saxi_wr.sv

// File: Makefile
TOP := tb_mult_saxi_wr
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
